// ==== common/muladd_consts.svh ====
`ifndef MULADD_CONSTS_SVH
`define MULADD_CONSTS_SVH

// one data word on the flow bus
`define DATA_W 32

// lanes in the array and slots on the shared bus
`define N_LANES 4
`define N_SLOTS 4

// slot select width, enough for zero, a, b and c
`define SEL_W 2

// source fifo, also the producer's starting credits
`define SRC_DEPTH 4

// collector fifo, also the source's starting credits toward it
`define COLL_DEPTH 4

// consumer buffer depth seen by the collector
`define OUT_CREDITS 4

// flow_valid to lane_valid in cycles
`define LANE_LAT 3

`endif

// ==== common/muladd_pkg.sv ====
`include "muladd_consts.svh"

package muladd_pkg;

   // lane operation, result is always the upper word of a 64-bit value
   typedef enum logic [2:0] {
      op_macc,       // acc + 2p
      op_macc_div2,  // acc + p
      op_msub,       // acc - 2p
      op_msub_div2,  // acc - p
      op_mul,        // 2p
      op_mul_div2,   // p
      op_mul_low,    // p << 32, gives low product word
      op_macc_16q16  // acc + q16.16 product in upper word
   } muladd_op_e;

   // one word on the flow bus
   typedef logic [`DATA_W-1:0] word_t;

   // select of one flow bus slot
   typedef logic [`SEL_W-1:0] sel_t;

   // full width signed product and accumulator
   typedef logic signed [2*`DATA_W-1:0] prod_t;

endpackage

// ==== src/lane_config.sv ====
`timescale 1ns/1ns
`include "muladd_consts.svh"

module lane_config (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  cfg_we,
   input  logic [$clog2(`N_LANES)-1:0]           cfg_lane,
   input  muladd_pkg::sel_t                      cfg_sela,
   input  muladd_pkg::sel_t                      cfg_selb,
   input  muladd_pkg::sel_t                      cfg_selo,
   input  muladd_pkg::muladd_op_e                cfg_op,
   output muladd_pkg::sel_t       [`N_LANES-1:0] lane_sela,
   output muladd_pkg::sel_t       [`N_LANES-1:0] lane_selb,
   output muladd_pkg::sel_t       [`N_LANES-1:0] lane_selo,
   output muladd_pkg::muladd_op_e [`N_LANES-1:0] lane_op
);

   // one register set per lane, written one lane at a time
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < `N_LANES; i++) begin
            lane_sela[i] <= muladd_pkg::sel_t'(1); // slot a
            lane_selb[i] <= muladd_pkg::sel_t'(2); // slot b
            lane_selo[i] <= muladd_pkg::sel_t'(3); // slot c as restart word
            lane_op[i]   <= muladd_pkg::op_mul;
         end
      end else if (cfg_we) begin
         lane_sela[cfg_lane] <= cfg_sela;
         lane_selb[cfg_lane] <= cfg_selb;
         lane_selo[cfg_lane] <= cfg_selo;
         lane_op[cfg_lane]   <= cfg_op;
      end
   end

endmodule

// ==== src/flow_source.sv ====
`timescale 1ns/1ns
`include "muladd_consts.svh"

module flow_source (
   input  logic              clk,
   input  logic              rst,
   input  logic              in_valid,
   input  muladd_pkg::word_t in_a,
   input  muladd_pkg::word_t in_b,
   input  muladd_pkg::word_t in_c,
   output logic              in_credit,
   input  logic              coll_credit,
   output logic              flow_valid,
   output muladd_pkg::word_t flow_a,
   output muladd_pkg::word_t flow_b,
   output muladd_pkg::word_t flow_c
);

   localparam int PTR_W = $clog2(`SRC_DEPTH);
   localparam int CNT_W = $clog2(`SRC_DEPTH + 1);
   localparam int CRD_W = $clog2(`COLL_DEPTH + 1);

   muladd_pkg::word_t mem_a [`SRC_DEPTH];
   muladd_pkg::word_t mem_b [`SRC_DEPTH];
   muladd_pkg::word_t mem_c [`SRC_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CRD_W-1:0] coll_cnt; // free entries in the collector fifo
   logic             issue;

   // only send what the collector is known to have room for
   assign issue = (count != '0) && (coll_cnt != '0);

   // a beat leaving the fifo frees one producer slot
   assign in_credit = flow_valid;

   always_ff @(posedge clk) begin
      if (in_valid) begin
         mem_a[wr_ptr] <= in_a;
         mem_b[wr_ptr] <= in_b;
         mem_c[wr_ptr] <= in_c;
      end
      if (issue) begin
         flow_a <= mem_a[rd_ptr];
         flow_b <= mem_b[rd_ptr];
         flow_c <= mem_c[rd_ptr];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         coll_cnt   <= CRD_W'(`COLL_DEPTH);
         flow_valid <= 1'b0;
      end else begin
         if (in_valid) begin
            wr_ptr <= (wr_ptr == PTR_W'(`SRC_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (issue) begin
            rd_ptr <= (rd_ptr == PTR_W'(`SRC_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count      <= count + CNT_W'(in_valid) - CNT_W'(issue);
         coll_cnt   <= coll_cnt + CRD_W'(coll_credit) - CRD_W'(issue);
         flow_valid <= issue;
      end
   end

   // producer sent without holding a credit
   a_no_overflow: assert property (
      @(posedge clk) disable iff (rst)
      in_valid |-> (count != CNT_W'(`SRC_DEPTH))
   );

   // collector returned more credits than it owns
   a_coll_credit_range: assert property (
      @(posedge clk) disable iff (rst)
      coll_cnt <= CRD_W'(`COLL_DEPTH)
   );

endmodule

// ==== muladd_lane/mul_pipe.sv ====
`timescale 1ns/1ns
`include "muladd_consts.svh"

module mul_pipe (
   input  logic              clk,
   input  logic              rst,
   input  muladd_pkg::word_t op_a,
   input  muladd_pkg::word_t op_b,
   output muladd_pkg::prod_t product
);

   logic signed [`DATA_W-1:0] a_q;
   logic signed [`DATA_W-1:0] b_q;

   // stage 1 captures operands, stage 2 the full signed product
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         a_q     <= '0;
         b_q     <= '0;
         product <= '0;
      end else begin
         a_q     <= op_a;
         b_q     <= op_b;
         product <= a_q * b_q; // sign extended to 64 bits
      end
   end

endmodule

// ==== muladd_lane/muladd_lane.sv ====
`timescale 1ns/1ns
`include "muladd_consts.svh"

module muladd_lane (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   flow_valid,
   input  muladd_pkg::word_t      flow_a,
   input  muladd_pkg::word_t      flow_b,
   input  muladd_pkg::word_t      flow_c,
   input  muladd_pkg::sel_t       sela,
   input  muladd_pkg::sel_t       selb,
   input  muladd_pkg::sel_t       selo,
   input  muladd_pkg::muladd_op_e op,
   output logic                   lane_valid,
   output muladd_pkg::word_t      lane_result
);

   muladd_pkg::word_t [`N_SLOTS-1:0] slots;
   muladd_pkg::word_t                op_a;
   muladd_pkg::word_t                op_b;
   logic                             restart_zero;

   logic [`LANE_LAT-1:0]             v_q;   // valid alongside the pipeline
   logic [`LANE_LAT-2:0]             z_q;   // restart flag alongside multiplier stages
   muladd_pkg::prod_t                product;
   muladd_pkg::prod_t                base;
   muladd_pkg::prod_t                result;
   muladd_pkg::prod_t                acc;
   logic                             v_mul; // product valid this cycle

   // slot 0 is a constant zero
   assign slots = {flow_c, flow_b, flow_a, muladd_pkg::word_t'(0)};

   assign op_a         = slots[sela];
   assign op_b         = slots[selb];
   assign restart_zero = (slots[selo] == '0);

   mul_pipe u_mul (
      .clk     (clk),
      .rst     (rst),
      .op_a    (op_a),
      .op_b    (op_b),
      .product (product)
   );

   assign v_mul = v_q[`LANE_LAT-2];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         v_q <= '0;
         z_q <= '0;
      end else begin
         v_q <= {v_q[`LANE_LAT-2:0], flow_valid};
         z_q <= {z_q[`LANE_LAT-3:0], restart_zero};
      end
   end

   // stage 3, operation decode on the product
   always_comb begin
      base = z_q[`LANE_LAT-2] ? '0 : acc; // restart drops the old sum
      case (op)
         muladd_pkg::op_mul:        result = product <<< 1;
         muladd_pkg::op_mul_div2:   result = product;
         muladd_pkg::op_mul_low:    result = product <<< `DATA_W;
         muladd_pkg::op_macc:       result = base + (product <<< 1);
         muladd_pkg::op_macc_div2:  result = base + product;
         muladd_pkg::op_msub:       result = base - (product <<< 1);
         muladd_pkg::op_msub_div2:  result = base - product;
         muladd_pkg::op_macc_16q16: result = base + {product[47:16], {`DATA_W{1'b0}}};
         default:                   result = '0;
      endcase
   end

   // accumulator doubles as the result register
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc <= '0;
      end else if (v_mul) begin
         acc <= result;
      end
   end

   assign lane_valid  = v_q[`LANE_LAT-1];
   assign lane_result = acc[2*`DATA_W-1:`DATA_W]; // upper word

   // op must be a defined operation while a beat reaches decode
   a_op_legal: assert property (
      @(posedge clk) disable iff (rst)
      v_mul |-> op inside {muladd_pkg::op_macc, muladd_pkg::op_macc_div2,
                           muladd_pkg::op_msub, muladd_pkg::op_msub_div2,
                           muladd_pkg::op_mul, muladd_pkg::op_mul_div2,
                           muladd_pkg::op_mul_low, muladd_pkg::op_macc_16q16}
   );

endmodule

// ==== src/result_collector.sv ====
`timescale 1ns/1ns
`include "muladd_consts.svh"

module result_collector (
   input  logic                             clk,
   input  logic                             rst,
   input  logic              [`N_LANES-1:0] lane_valid,
   input  muladd_pkg::word_t [`N_LANES-1:0] lane_result,
   input  logic                             out_credit,
   output logic                             coll_credit,
   output logic                             out_valid,
   output logic     [`N_LANES*`DATA_W-1:0]  out_data
);

   localparam int PTR_W = $clog2(`COLL_DEPTH);
   localparam int CNT_W = $clog2(`COLL_DEPTH + 1);
   localparam int CRD_W = $clog2(`OUT_CREDITS + 1);

   logic [`N_LANES*`DATA_W-1:0] mem [`COLL_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CRD_W-1:0] out_cnt; // free space in the consumer
   logic             push;
   logic             pop;

   // lanes run in lock step, lane 0 speaks for all
   assign push = lane_valid[0];
   assign pop  = (count != '0) && (out_cnt != '0);

   assign out_valid = pop;
   assign out_data  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= lane_result; // lane 0 lands in the low word
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         out_cnt     <= CRD_W'(`OUT_CREDITS);
         coll_credit <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(`COLL_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(`COLL_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count       <= count + CNT_W'(push) - CNT_W'(pop);
         out_cnt     <= out_cnt + CRD_W'(out_credit) - CRD_W'(pop);
         coll_credit <= pop; // entry freed, tell the source
      end
   end

   // all lanes share one latency
   a_lanes_aligned: assert property (
      @(posedge clk) disable iff (rst)
      (lane_valid == '0) || (&lane_valid)
   );

   // source credits keep the fifo from overflowing
   a_no_overflow: assert property (
      @(posedge clk) disable iff (rst)
      push |-> (count != CNT_W'(`COLL_DEPTH))
   );

endmodule

// ==== src/muladd_array_top.sv ====
`timescale 1ns/1ns
`include "muladd_consts.svh"

module muladd_array_top (
   input  logic                         clk,
   input  logic                         rst,
   // producer side
   input  logic                         in_valid,
   input  muladd_pkg::word_t            in_a,
   input  muladd_pkg::word_t            in_b,
   input  muladd_pkg::word_t            in_c,
   output logic                         in_credit,
   // consumer side
   output logic                         out_valid,
   output logic [`N_LANES*`DATA_W-1:0]  out_data,
   input  logic                         out_credit,
   // configuration write port
   input  logic                         cfg_we,
   input  logic [$clog2(`N_LANES)-1:0]  cfg_lane,
   input  muladd_pkg::sel_t             cfg_sela,
   input  muladd_pkg::sel_t             cfg_selb,
   input  muladd_pkg::sel_t             cfg_selo,
   input  muladd_pkg::muladd_op_e       cfg_op
);

   muladd_pkg::sel_t       [`N_LANES-1:0] lane_sela;
   muladd_pkg::sel_t       [`N_LANES-1:0] lane_selb;
   muladd_pkg::sel_t       [`N_LANES-1:0] lane_selo;
   muladd_pkg::muladd_op_e [`N_LANES-1:0] lane_op;

   logic                                  flow_valid;
   muladd_pkg::word_t                     flow_a;
   muladd_pkg::word_t                     flow_b;
   muladd_pkg::word_t                     flow_c;
   logic                                  coll_credit;

   logic                   [`N_LANES-1:0] lane_valid;
   muladd_pkg::word_t      [`N_LANES-1:0] lane_result;

   lane_config u_cfg (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_lane  (cfg_lane),
      .cfg_sela  (cfg_sela),
      .cfg_selb  (cfg_selb),
      .cfg_selo  (cfg_selo),
      .cfg_op    (cfg_op),
      .lane_sela (lane_sela),
      .lane_selb (lane_selb),
      .lane_selo (lane_selo),
      .lane_op   (lane_op)
   );

   flow_source u_src (
      .clk         (clk),
      .rst         (rst),
      .in_valid    (in_valid),
      .in_a        (in_a),
      .in_b        (in_b),
      .in_c        (in_c),
      .in_credit   (in_credit),
      .coll_credit (coll_credit),
      .flow_valid  (flow_valid),
      .flow_a      (flow_a),
      .flow_b      (flow_b),
      .flow_c      (flow_c)
   );

   // every lane sees the same bus and valid
   for (genvar i = 0; i < `N_LANES; i++) begin : g_lane
      muladd_lane u_lane (
         .clk         (clk),
         .rst         (rst),
         .flow_valid  (flow_valid),
         .flow_a      (flow_a),
         .flow_b      (flow_b),
         .flow_c      (flow_c),
         .sela        (lane_sela[i]),
         .selb        (lane_selb[i]),
         .selo        (lane_selo[i]),
         .op          (lane_op[i]),
         .lane_valid  (lane_valid[i]),
         .lane_result (lane_result[i])
      );
   end

   result_collector u_coll (
      .clk         (clk),
      .rst         (rst),
      .lane_valid  (lane_valid),
      .lane_result (lane_result),
      .out_credit  (out_credit),
      .coll_credit (coll_credit),
      .out_valid   (out_valid),
      .out_data    (out_data)
   );

endmodule

// ==== test/tb_muladd_array.sv ====
`timescale 1ns/1ns
`include "muladd_consts.svh"

module tb_muladd_array;

   localparam int CLK_HALF  = 20;
   localparam int RST_CYC   = 16;
   localparam int ROW_LIMIT = 200; // watchdog budget per table row

   logic                        clk;
   logic                        rst;
   logic                        in_valid;
   muladd_pkg::word_t           in_a;
   muladd_pkg::word_t           in_b;
   muladd_pkg::word_t           in_c;
   logic                        in_credit;
   logic                        out_valid;
   logic [`N_LANES*`DATA_W-1:0] out_data;
   logic                        out_credit;
   logic                        cfg_we;
   logic [1:0]                  cfg_lane;
   muladd_pkg::sel_t            cfg_sela;
   muladd_pkg::sel_t            cfg_selb;
   muladd_pkg::sel_t            cfg_selo;
   muladd_pkg::muladd_op_e      cfg_op;

   // lane configurations 1 to 3, one column per lane
   muladd_pkg::sel_t cfg_sa_t [3][4] = '{'{1, 1, 1, 1}, '{1, 1, 1, 1}, '{1, 1, 1, 3}};
   muladd_pkg::sel_t cfg_sb_t [3][4] = '{'{2, 2, 2, 2}, '{2, 2, 2, 2}, '{2, 2, 0, 1}};
   muladd_pkg::sel_t cfg_so_t [3][4] = '{'{3, 3, 3, 3}, '{3, 3, 3, 3}, '{3, 0, 3, 2}};
   muladd_pkg::muladd_op_e cfg_op_t [3][4] = '{
      '{muladd_pkg::op_macc, muladd_pkg::op_macc_div2,
        muladd_pkg::op_msub, muladd_pkg::op_msub_div2},
      '{muladd_pkg::op_mul, muladd_pkg::op_mul_div2,
        muladd_pkg::op_mul_low, muladd_pkg::op_macc_16q16},
      '{muladd_pkg::op_macc, muladd_pkg::op_macc_div2,
        muladd_pkg::op_macc, muladd_pkg::op_msub}};

   // reference model state per lane
   muladd_pkg::sel_t       m_sela [`N_LANES];
   muladd_pkg::sel_t       m_selb [`N_LANES];
   muladd_pkg::sel_t       m_selo [`N_LANES];
   muladd_pkg::muladd_op_e m_op [`N_LANES];
   logic signed [63:0]     macc [`N_LANES];

   // stimulus table, expected lane 0 word where chk is set
   int                          row_cfg [$];
   muladd_pkg::word_t           row_a [$];
   muladd_pkg::word_t           row_b [$];
   muladd_pkg::word_t           row_c [$];
   bit                          row_rnd [$];
   int                          row_hold [$];
   muladd_pkg::word_t           row_exp0 [$];
   bit                          row_chk [$];

   muladd_pkg::word_t           pend_a [$];
   muladd_pkg::word_t           pend_b [$];
   muladd_pkg::word_t           pend_c [$];
   logic [`N_LANES*`DATA_W-1:0] exp_q [$];
   int                          exp_hold [$];
   muladd_pkg::word_t           exp_w0 [$];
   bit                          exp_chk [$];
   int                          rel_q [$]; // cycle at which each credit goes back

   int          n_queued = 0;
   int          n_sent = 0;
   int          n_in_credit = 0;
   int          n_out = 0;
   int          n_returned = 0;
   int          peak = 0;
   int          n_data_err = 0;
   int          n_count_err = 0;
   int          n_proto_err = 0;
   logic [31:0] lfsr_state = 32'h9dba28e3;

   muladd_array_top u_dut (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_a       (in_a),
      .in_b       (in_b),
      .in_c       (in_c),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_credit (out_credit),
      .cfg_we     (cfg_we),
      .cfg_lane   (cfg_lane),
      .cfg_sela   (cfg_sela),
      .cfg_selb   (cfg_selb),
      .cfg_selo   (cfg_selo),
      .cfg_op     (cfg_op)
   );

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic muladd_pkg::word_t draw_word();
      muladd_pkg::word_t w;
      w = '0;
      for (int i = 0; i < `DATA_W; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         w = {w[`DATA_W-2:0], lfsr_state[0]};
      end
      return w;
   endfunction

   task automatic check_word(input string name, input muladd_pkg::word_t got,
                             input muladd_pkg::word_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
         n_data_err++;
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
         n_count_err++;
      end
   endtask

   task automatic flag_problem(input string msg);
      $display("ERROR %s at %0t", msg, $time);
      n_proto_err++;
   endtask

   task automatic add_row(input int cfg, input muladd_pkg::word_t a, input muladd_pkg::word_t b,
                          input muladd_pkg::word_t c, input bit rnd, input int hold,
                          input muladd_pkg::word_t exp0, input bit chk);
      row_cfg.push_back(cfg);
      row_a.push_back(a);
      row_b.push_back(b);
      row_c.push_back(c);
      row_rnd.push_back(rnd);
      row_hold.push_back(hold);
      row_exp0.push_back(exp0);
      row_chk.push_back(chk);
   endtask

   // one beat through every lane model, accumulators updated
   task automatic model_beat(input muladd_pkg::word_t a, input muladd_pkg::word_t b,
                             input muladd_pkg::word_t c,
                             output logic [`N_LANES*`DATA_W-1:0] exp);
      muladd_pkg::word_t  slot [4];
      logic signed [63:0] p;
      logic signed [63:0] base;
      logic signed [63:0] r;
      slot[0] = '0;
      slot[1] = a;
      slot[2] = b;
      slot[3] = c;
      for (int l = 0; l < `N_LANES; l++) begin
         p    = $signed(slot[m_sela[l]]) * $signed(slot[m_selb[l]]);
         base = (slot[m_selo[l]] == '0) ? '0 : macc[l];
         case (m_op[l])
            muladd_pkg::op_mul:        r = 2 * p;
            muladd_pkg::op_mul_div2:   r = p;
            muladd_pkg::op_mul_low:    r = {p[31:0], 32'h0};
            muladd_pkg::op_macc:       r = base + 2 * p;
            muladd_pkg::op_macc_div2:  r = base + p;
            muladd_pkg::op_msub:       r = base - 2 * p;
            muladd_pkg::op_msub_div2:  r = base - p;
            muladd_pkg::op_macc_16q16: r = base + {p[47:16], 32'h0};
         endcase
         macc[l] = r;
         exp[l*`DATA_W +: `DATA_W] = r[63:32];
      end
   endtask

   // config may only change with the array drained
   task automatic apply_cfg(input int id);
      while (n_out != n_queued) @(negedge clk);
      for (int l = 0; l < `N_LANES; l++) begin
         @(negedge clk);
         cfg_we   = 1'b1;
         cfg_lane = 2'(l);
         cfg_sela = cfg_sa_t[id-1][l];
         cfg_selb = cfg_sb_t[id-1][l];
         cfg_selo = cfg_so_t[id-1][l];
         cfg_op   = cfg_op_t[id-1][l];
         m_sela[l] = cfg_sa_t[id-1][l];
         m_selb[l] = cfg_sb_t[id-1][l];
         m_selo[l] = cfg_so_t[id-1][l];
         m_op[l]   = cfg_op_t[id-1][l];
      end
      @(negedge clk);
      cfg_we = 1'b0;
   endtask

   task automatic finish_run(input bit timed_out);
      $display("errors: data %0d, count %0d, protocol %0d", n_data_err, n_count_err, n_proto_err);
      if (!timed_out && (n_data_err + n_count_err + n_proto_err == 0)) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   endtask

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // producer, consumer and credit bookkeeping, all on the falling edge
   initial begin
      int                          cyc;
      int                          credits;
      bit                          chk;
      muladd_pkg::word_t           w0;
      logic [`N_LANES*`DATA_W-1:0] exp;
      cyc     = 0;
      credits = `SRC_DEPTH;
      forever begin
         @(negedge clk);
         if (!rst) begin
            cyc++;
            if (n_sent == 0 && (in_credit || out_valid))
               flag_problem("in_credit or out_valid active before any beat was sent");
            if (in_credit) begin
               credits++;
               n_in_credit++;
            end
            if (pend_a.size() > 0 && credits > 0) begin
               in_valid = 1'b1;
               in_a     = pend_a.pop_front();
               in_b     = pend_b.pop_front();
               in_c     = pend_c.pop_front();
               credits--;
               n_sent++;
            end else begin
               in_valid = 1'b0;
            end
            if (out_valid) begin
               if (exp_q.size() == 0) begin
                  flag_problem("out_valid with no beat outstanding");
               end else begin
                  exp = exp_q.pop_front();
                  chk = exp_chk.pop_front();
                  w0  = exp_w0.pop_front();
                  for (int l = 0; l < `N_LANES; l++)
                     check_word($sformatf("out_data lane %0d", l),
                                out_data[l*`DATA_W +: `DATA_W], exp[l*`DATA_W +: `DATA_W]);
                  if (chk) check_word("out_data lane 0 vs table", out_data[`DATA_W-1:0], w0);
                  rel_q.push_back(cyc + exp_hold.pop_front());
               end
               n_out++;
            end
            if (rel_q.size() > 0 && rel_q[0] <= cyc) begin
               out_credit = 1'b1;
               void'(rel_q.pop_front());
               n_returned++;
            end else begin
               out_credit = 1'b0;
            end
            if (n_out - n_returned > peak) peak = n_out - n_returned;
            if (n_out - n_returned > `OUT_CREDITS)
               flag_problem("more results than consumer credits");
            if (n_in_credit - n_returned > `COLL_DEPTH + `OUT_CREDITS)
               flag_problem("source kept issuing under back-pressure");
         end
      end
   end

   initial begin
      muladd_pkg::word_t           a;
      muladd_pkg::word_t           b;
      muladd_pkg::word_t           c;
      logic [`N_LANES*`DATA_W-1:0] exp;
      rst        = 1'b1;
      in_valid   = 1'b0;
      in_a       = '0;
      in_b       = '0;
      in_c       = '0;
      out_credit = 1'b0;
      cfg_we     = 1'b0;
      cfg_lane   = '0;
      cfg_sela   = '0;
      cfg_selb   = '0;
      cfg_selo   = '0;
      cfg_op     = muladd_pkg::op_mul;
      for (int l = 0; l < `N_LANES; l++) begin
         m_sela[l] = 1;
         m_selb[l] = 2;
         m_selo[l] = 3;
         m_op[l]   = muladd_pkg::op_mul;
         macc[l]   = '0;
      end
      // cfg, a, b, c, random, hold, lane 0 word, check it
      add_row(0, 32'h4000_0000, 32'h6, 32'h1, 0, 0, 32'h3, 1);
      add_row(0, 32'hffff_fffe, 32'h7, 32'h5, 0, 0, 32'hffff_ffff, 1);
      add_row(1, 0, 0, 0, 1, 0, 0, 0);
      add_row(0, 0, 0, 0, 1, 0, 0, 0);
      add_row(0, 0, 0, 0, 1, 0, 0, 0);
      add_row(2, 0, 0, 0, 1, 0, 0, 0);
      add_row(0, 0, 0, 0, 1, 0, 0, 0);
      add_row(0, 0, 0, 0, 1, 0, 0, 0);
      add_row(3, 32'h1_0000, 32'h1_0000, 32'h0, 0, 0, 32'h2, 1); // restart
      add_row(0, 32'h1_0000, 32'h1_0000, 32'h5, 0, 0, 32'h4, 1); // sums on
      add_row(0, 0, 0, 0, 1, 0, 0, 0);
      add_row(0, 0, 0, 0, 1, 0, 0, 0);
      add_row(0, 32'h7, 32'h3, 32'h0, 0, 0, 0, 0);
      add_row(0, 0, 0, 0, 1, 0, 0, 0);
      add_row(1, 0, 0, 0, 1, 80, 0, 0); // long stall downstream
      for (int i = 0; i < 10; i++) add_row(0, 0, 0, 0, 1, 0, 0, 0);
      fork
         begin
            #((row_cfg.size() * ROW_LIMIT + RST_CYC) * 2 * CLK_HALF);
            $display("timeout: only %0d of %0d beats came out", n_out, n_queued);
            finish_run(1);
         end
      join_none
      repeat (RST_CYC) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      repeat (4) @(negedge clk); // quiet bus after reset
      for (int r = 0; r < row_cfg.size(); r++) begin
         if (row_cfg[r] != 0) apply_cfg(row_cfg[r]);
         a = row_rnd[r] ? draw_word() : row_a[r];
         b = row_rnd[r] ? draw_word() : row_b[r];
         c = row_rnd[r] ? draw_word() : row_c[r];
         model_beat(a, b, c, exp);
         exp_q.push_back(exp);
         exp_hold.push_back(row_hold[r]);
         exp_w0.push_back(row_exp0[r]);
         exp_chk.push_back(row_chk[r]);
         pend_a.push_back(a);
         pend_b.push_back(b);
         pend_c.push_back(c);
         n_queued++;
      end
      while (n_out != n_queued) @(negedge clk);
      repeat (8) @(negedge clk);
      check_count("in_credit pulses", n_in_credit, n_queued);
      check_count("out_valid beats", n_out, n_queued);
      check_count("out_credit returns", n_returned, n_queued);
      check_count("peak unanswered results", peak, `OUT_CREDITS);
      finish_run(0);
   end

endmodule

// ==== sources.f ====
+incdir+common
common/muladd_pkg.sv
src/lane_config.sv
src/flow_source.sv
muladd_lane/mul_pipe.sv
muladd_lane/muladd_lane.sv
src/result_collector.sv
src/muladd_array_top.sv
test/tb_muladd_array.sv
